// File: design/lookup_cfg.svh
`ifndef LOOKUP_CFG_SVH
`define LOOKUP_CFG_SVH

// datapath widths
`define LE_KEY_W        32
`define LE_ACT_W        64
`define LE_PHV_W        32

// table geometry
`define LE_DEPTH        16
`define LE_IDX_W        4

// control stream
`define LE_CDATA_W      64
`define LE_STAGE_ID     0
`define LE_LOOKUP_ID    2
`define LE_CTRL_FLAG    16'hf2f1

// action returned on a miss
`define LE_DEFAULT_ACT  64'h3f

// header beat field positions
`define LE_HDR_FLAG_LSB 48
`define LE_HDR_MOD_LSB  40
`define LE_HDR_SEL_LSB  36
`define LE_HDR_IDX_LSB  0

`endif

// File: design/lookup_pkg.sv
`include "lookup_cfg.svh"

package lookup_pkg;

    // lookup datapath words
    typedef logic [`LE_KEY_W-1:0] key_t;
    typedef logic [`LE_ACT_W-1:0] action_t;
    typedef logic [`LE_PHV_W-1:0] phv_t;
    typedef logic [`LE_IDX_W-1:0] idx_t;

    // lookup sequencer
    typedef enum logic [1:0] {
        LK_IDLE,
        LK_CAM,
        LK_READ,
        LK_OUT
    } lookup_state_e;

endpackage

// File: design/ctrl_pkg.sv
package ctrl_pkg;

    // table select field of the header beat
    // anything other than zero targets the action table
    typedef enum logic [3:0] {
        TBL_CAM = 4'd0,
        TBL_ACT = 4'd1
    } table_sel_e;

    // control stream parser
    typedef enum logic [1:0] {
        CT_IDLE,
        CT_CAM,
        CT_ACT,
        CT_FWD
    } ctrl_state_e;

endpackage

// File: design/key_cam.sv
`include "lookup_cfg.svh"

module key_cam (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             cmp_en,
    input  lookup_pkg::key_t cmp_key,
    input  logic             cam_wr_en,
    input  lookup_pkg::idx_t cam_wr_idx,
    input  lookup_pkg::key_t cam_wr_key,
    output logic             hit,
    output lookup_pkg::idx_t hit_idx
);
    import lookup_pkg::*;

    key_t                 entry_key [`LE_DEPTH];
    logic [`LE_DEPTH-1:0] entry_vld;
    logic                 match_any;
    idx_t                 match_idx;

    // walk down so the lowest matching entry is left standing
    always_comb begin
        match_any = 1'b0;
        match_idx = '0;
        for (int i = `LE_DEPTH - 1; i >= 0; i--) begin
            if (entry_vld[i] && (entry_key[i] == cmp_key)) begin
                match_any = 1'b1;
                match_idx = idx_t'(i);
            end
        end
    end

    // key storage
    always_ff @(posedge clk) begin
        if (cam_wr_en) begin
            entry_key[cam_wr_idx] <= cam_wr_key;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_vld <= '0;
            hit       <= 1'b0;
        end else begin
            if (cam_wr_en) begin
                entry_vld[cam_wr_idx] <= 1'b1;
            end
            if (cmp_en) begin
                hit <= match_any;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmp_en) begin
            hit_idx <= match_idx;
        end
    end

endmodule

// File: design/action_table_arbiter.sv
`include "lookup_cfg.svh"

module action_table_arbiter (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                rd_req,
    input  lookup_pkg::idx_t    rd_idx,
    output lookup_pkg::action_t rd_data,
    input  logic                act_wr_req,
    input  lookup_pkg::idx_t    act_wr_idx,
    input  lookup_pkg::action_t act_wr_data,
    output logic                act_wr_gnt
);
    import lookup_pkg::*;

    action_t mem [`LE_DEPTH];
    idx_t    port_addr;
    logic    port_we;

    // reads always win, a pending write takes any idle cycle
    assign port_we    = act_wr_req & ~rd_req;
    assign port_addr  = rd_req ? rd_idx : act_wr_idx;
    assign act_wr_gnt = port_we;

    // one shared port, either a read or a write per cycle
    always_ff @(posedge clk) begin
        if (port_we) begin
            mem[port_addr] <= act_wr_data;
        end
    end

    // read data lands one cycle after the request
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_data <= '0;
        end else if (rd_req) begin
            rd_data <= mem[port_addr];
        end
    end

endmodule

// File: design/lookup_ctrl.sv
`include "lookup_cfg.svh"

module lookup_ctrl (
    input  logic                clk,
    input  logic                rst_n,

    // key side
    input  logic                key_valid,
    output logic                key_ready,
    input  lookup_pkg::key_t    key,
    input  lookup_pkg::phv_t    phv_in,

    // action side
    output logic                action_valid,
    input  logic                action_ready,
    output lookup_pkg::action_t action,
    output lookup_pkg::phv_t    phv_out,

    // cam compare
    output logic                cmp_en,
    output lookup_pkg::key_t    cmp_key,
    input  logic                hit,
    input  lookup_pkg::idx_t    hit_idx,

    // action table read
    output logic                rd_req,
    output lookup_pkg::idx_t    rd_idx,
    input  lookup_pkg::action_t rd_data
);
    import lookup_pkg::*;

    lookup_state_e state;
    key_t          key_q;
    logic          key_fire;
    logic          act_fire;

    assign key_fire = key_valid & key_ready;
    assign act_fire = action_valid & action_ready;

    // only one lookup in flight
    assign key_ready = (state == LK_IDLE);

    assign cmp_en  = (state == LK_CAM);
    assign cmp_key = key_q;

    // cam result is visible in LK_READ
    assign rd_req = (state == LK_READ) & hit;
    assign rd_idx = hit_idx;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state        <= LK_IDLE;
            action_valid <= 1'b0;
        end else begin
            case (state)
                LK_IDLE: begin
                    if (key_fire) begin
                        state <= LK_CAM;
                    end
                end
                LK_CAM: begin
                    state <= LK_READ;
                end
                LK_READ: begin
                    // a miss is ready right away, a hit waits for the table
                    state <= LK_OUT;
                    if (!hit) begin
                        action_valid <= 1'b1;
                    end
                end
                LK_OUT: begin
                    if (!action_valid) begin
                        action_valid <= 1'b1;
                    end else if (act_fire) begin
                        action_valid <= 1'b0;
                        state        <= LK_IDLE;
                    end
                end
                default: begin
                    state <= LK_IDLE;
                end
            endcase
        end
    end

    // result payload
    always_ff @(posedge clk) begin
        if (key_fire) begin
            key_q   <= key;
            phv_out <= phv_in;
        end
        if ((state == LK_READ) && !hit) begin
            action <= `LE_DEFAULT_ACT;
        end
        if ((state == LK_OUT) && !action_valid) begin
            action <= rd_data;
        end
    end

endmodule

// File: design/ctrl_parser.sv
`include "lookup_cfg.svh"

module ctrl_parser (
    input  logic                    clk,
    input  logic                    rst_n,

    // control stream in
    input  logic                    c_s_valid,
    output logic                    c_s_ready,
    input  logic [`LE_CDATA_W-1:0]  c_s_data,
    input  logic                    c_s_last,

    // forwarded stream out
    output logic                    c_m_valid,
    output logic [`LE_CDATA_W-1:0]  c_m_data,
    output logic                    c_m_last,

    // cam write port
    output logic                    cam_wr_en,
    output lookup_pkg::idx_t        cam_wr_idx,
    output lookup_pkg::key_t        cam_wr_key,

    // action table write request
    output logic                    act_wr_req,
    output lookup_pkg::idx_t        act_wr_idx,
    output lookup_pkg::action_t     act_wr_data,
    input  logic                    act_wr_gnt
);
    import lookup_pkg::*;
    import ctrl_pkg::*;

    ctrl_state_e state;
    idx_t        tbl_idx;
    logic        s_fire;
    logic [15:0] hdr_flag;
    logic [7:0]  hdr_mod;
    table_sel_e  hdr_tbl;
    logic        hdr_match;

    // header fields
    assign hdr_flag = c_s_data[`LE_HDR_FLAG_LSB +: 16];
    assign hdr_mod  = c_s_data[`LE_HDR_MOD_LSB +: 8];
    assign hdr_tbl  = (c_s_data[`LE_HDR_SEL_LSB +: 4] == 4'd0) ? TBL_CAM : TBL_ACT;

    // stage id in the upper five bits, lookup id in the lower three
    assign hdr_match = (hdr_mod[7:3] == 5'(`LE_STAGE_ID)) &&
                       (hdr_mod[2:0] == 3'(`LE_LOOKUP_ID)) &&
                       (hdr_flag == `LE_CTRL_FLAG);

    // stall while an action write waits for its grant
    assign c_s_ready = ~act_wr_req;
    assign s_fire    = c_s_valid & c_s_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= CT_IDLE;
            c_m_valid  <= 1'b0;
            cam_wr_en  <= 1'b0;
            act_wr_req <= 1'b0;
        end else begin
            c_m_valid <= 1'b0;
            cam_wr_en <= 1'b0;
            if (act_wr_gnt) begin
                act_wr_req <= 1'b0;
            end
            if (s_fire) begin
                case (state)
                    CT_IDLE: begin
                        if (hdr_match) begin
                            // addressed packets are consumed here
                            if (!c_s_last) begin
                                state <= (hdr_tbl == TBL_CAM) ? CT_CAM : CT_ACT;
                            end
                        end else begin
                            c_m_valid <= 1'b1;
                            if (!c_s_last) begin
                                state <= CT_FWD;
                            end
                        end
                    end
                    CT_FWD: begin
                        c_m_valid <= 1'b1;
                        if (c_s_last) begin
                            state <= CT_IDLE;
                        end
                    end
                    CT_CAM: begin
                        cam_wr_en <= 1'b1;
                        if (c_s_last) begin
                            state <= CT_IDLE;
                        end
                    end
                    CT_ACT: begin
                        act_wr_req <= 1'b1;
                        if (c_s_last) begin
                            state <= CT_IDLE;
                        end
                    end
                    default: begin
                        state <= CT_IDLE;
                    end
                endcase
            end
        end
    end

    // beat payload and entry index
    always_ff @(posedge clk) begin
        if (s_fire) begin
            c_m_data <= c_s_data;
            c_m_last <= c_s_last;
            case (state)
                CT_IDLE: begin
                    tbl_idx <= c_s_data[`LE_HDR_IDX_LSB +: `LE_IDX_W];
                end
                CT_CAM: begin
                    cam_wr_idx <= tbl_idx;
                    cam_wr_key <= c_s_data[`LE_KEY_W-1:0];
                    tbl_idx    <= tbl_idx + 1'b1;
                end
                CT_ACT: begin
                    act_wr_idx  <= tbl_idx;
                    act_wr_data <= c_s_data;
                    tbl_idx     <= tbl_idx + 1'b1;
                end
                default: begin
                    tbl_idx <= tbl_idx;
                end
            endcase
        end
    end

endmodule

// File: design/lookup_engine.sv
`include "lookup_cfg.svh"

module lookup_engine (
    input  logic                    clk,
    input  logic                    rst_n,

    // lookup in
    input  logic                    key_valid,
    output logic                    key_ready,
    input  lookup_pkg::key_t        key,
    input  lookup_pkg::phv_t        phv_in,

    // lookup out
    output logic                    action_valid,
    input  logic                    action_ready,
    output lookup_pkg::action_t     action,
    output lookup_pkg::phv_t        phv_out,

    // control in
    input  logic                    c_s_valid,
    output logic                    c_s_ready,
    input  logic [`LE_CDATA_W-1:0]  c_s_data,
    input  logic                    c_s_last,

    // control out is always accepted downstream
    output logic                    c_m_valid,
    output logic [`LE_CDATA_W-1:0]  c_m_data,
    output logic                    c_m_last
);

    // compare path
    logic                cmp_en;
    lookup_pkg::key_t    cmp_key;
    logic                hit;
    lookup_pkg::idx_t    hit_idx;

    // action table read
    logic                rd_req;
    lookup_pkg::idx_t    rd_idx;
    lookup_pkg::action_t rd_data;

    // table programming
    logic                cam_wr_en;
    lookup_pkg::idx_t    cam_wr_idx;
    lookup_pkg::key_t    cam_wr_key;
    logic                act_wr_req;
    lookup_pkg::idx_t    act_wr_idx;
    lookup_pkg::action_t act_wr_data;
    logic                act_wr_gnt;

    lookup_ctrl i_lookup_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_ready    (key_ready),
        .key          (key),
        .phv_in       (phv_in),
        .action_valid (action_valid),
        .action_ready (action_ready),
        .action       (action),
        .phv_out      (phv_out),
        .cmp_en       (cmp_en),
        .cmp_key      (cmp_key),
        .hit          (hit),
        .hit_idx      (hit_idx),
        .rd_req       (rd_req),
        .rd_idx       (rd_idx),
        .rd_data      (rd_data)
    );

    key_cam i_key_cam (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmp_en     (cmp_en),
        .cmp_key    (cmp_key),
        .cam_wr_en  (cam_wr_en),
        .cam_wr_idx (cam_wr_idx),
        .cam_wr_key (cam_wr_key),
        .hit        (hit),
        .hit_idx    (hit_idx)
    );

    action_table_arbiter i_action_table_arbiter (
        .clk         (clk),
        .rst_n       (rst_n),
        .rd_req      (rd_req),
        .rd_idx      (rd_idx),
        .rd_data     (rd_data),
        .act_wr_req  (act_wr_req),
        .act_wr_idx  (act_wr_idx),
        .act_wr_data (act_wr_data),
        .act_wr_gnt  (act_wr_gnt)
    );

    ctrl_parser i_ctrl_parser (
        .clk         (clk),
        .rst_n       (rst_n),
        .c_s_valid   (c_s_valid),
        .c_s_ready   (c_s_ready),
        .c_s_data    (c_s_data),
        .c_s_last    (c_s_last),
        .c_m_valid   (c_m_valid),
        .c_m_data    (c_m_data),
        .c_m_last    (c_m_last),
        .cam_wr_en   (cam_wr_en),
        .cam_wr_idx  (cam_wr_idx),
        .cam_wr_key  (cam_wr_key),
        .act_wr_req  (act_wr_req),
        .act_wr_idx  (act_wr_idx),
        .act_wr_data (act_wr_data),
        .act_wr_gnt  (act_wr_gnt)
    );

endmodule

// File: test/lookup_engine_asserts.sv
module lookup_engine_asserts (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                key_ready,
    input  logic                action_valid,
    input  logic                action_ready,
    input  lookup_pkg::action_t action,
    input  lookup_pkg::phv_t    phv_out,
    input  logic                c_s_ready,
    input  logic                act_wr_req,
    input  logic                act_wr_gnt
);

    // number of assertion failures so far
    int fail_cnt = 0;

    // result held steady while downstream stalls
    a_action_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        (action_valid && !action_ready) |=> (action_valid && $stable(action) && $stable(phv_out))
    ) else begin
        $error("action result changed while action_ready was low");
        fail_cnt++;
    end

    // one lookup in flight
    a_single_flight: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(key_ready && action_valid)
    ) else begin
        $error("key_ready and action_valid high together");
        fail_cnt++;
    end

    // control input stalls no longer than the pending action write
    a_ctrl_stall: assert property (
        @(posedge clk) disable iff (!rst_n)
        (act_wr_req && act_wr_gnt) |=> c_s_ready
    ) else begin
        $error("c_s_ready still low after the action write was granted");
        fail_cnt++;
    end

endmodule

bind lookup_engine lookup_engine_asserts i_lookup_engine_asserts (
    .clk          (clk),
    .rst_n        (rst_n),
    .key_ready    (key_ready),
    .action_valid (action_valid),
    .action_ready (action_ready),
    .action       (action),
    .phv_out      (phv_out),
    .c_s_ready    (c_s_ready),
    .act_wr_req   (act_wr_req),
    .act_wr_gnt   (act_wr_gnt)
);

// File: test/tb_lookup_engine.sv
`include "lookup_cfg.svh"

module tb_lookup_engine;
    import lookup_pkg::*;
    import ctrl_pkg::*;

    localparam int HALF_PERIOD = 20;
    localparam int DRIVE_DLY   = 2;
    localparam int CYCLE_LIMIT = 2000;
    localparam int WAIT_LIMIT  = 20;
    localparam int BASE_IDX    = 3;
    localparam logic [7:0] OWN_ID = {5'(`LE_STAGE_ID), 3'(`LE_LOOKUP_ID)};

    logic                   clk;
    logic                   rst_n;
    logic                   key_valid;
    logic                   key_ready;
    key_t                   key;
    phv_t                   phv_in;
    logic                   action_valid;
    logic                   action_ready;
    action_t                action;
    phv_t                   phv_out;
    logic                   c_s_valid;
    logic                   c_s_ready;
    logic [`LE_CDATA_W-1:0] c_s_data;
    logic                   c_s_last;
    logic                   c_m_valid;
    logic [`LE_CDATA_W-1:0] c_m_data;
    logic                   c_m_last;

    // reference copy of the table contents
    key_t    model_key [`LE_DEPTH];
    logic    model_vld [`LE_DEPTH];
    action_t model_act [`LE_DEPTH];
    key_t    prog_key  [3];

    int errors       = 0;
    int tests_run    = 0;
    int tests_failed = 0;
    int cycle_cnt    = 0;
    int fwd_seen     = 0;
    int assert_fails;

    lookup_engine i_dut (
        .clk          (clk),
        .rst_n        (rst_n),
        .key_valid    (key_valid),
        .key_ready    (key_ready),
        .key          (key),
        .phv_in       (phv_in),
        .action_valid (action_valid),
        .action_ready (action_ready),
        .action       (action),
        .phv_out      (phv_out),
        .c_s_valid    (c_s_valid),
        .c_s_ready    (c_s_ready),
        .c_s_data     (c_s_data),
        .c_s_last     (c_s_last),
        .c_m_valid    (c_m_valid),
        .c_m_data     (c_m_data),
        .c_m_last     (c_m_last)
    );

    always #HALF_PERIOD clk = ~clk;

    // cycle limit and forwarded beat count
    always @(posedge clk) begin
        cycle_cnt++;
        if (c_m_valid === 1'b1) begin
            fwd_seen++;
        end
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("timeout: run exceeded %0d cycles", CYCLE_LIMIT);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    task automatic tick();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        errors++;
    endtask

    task automatic report_failure(input string what);
        $display("ERROR at %0t: %s", $time, what);
        errors++;
    endtask

    task automatic finish_test(input string name, input int start_err);
        tests_run++;
        if (errors > start_err) begin
            tests_failed++;
            $display("test %s: FAILED with %0d errors", name, errors - start_err);
        end else begin
            $display("test %s: passed", name);
        end
    endtask

    function automatic logic [`LE_CDATA_W-1:0] make_header(input logic [15:0] flag,
                                                          input logic [7:0] mod_id,
                                                          input logic [3:0] sel,
                                                          input idx_t idx);
        logic [`LE_CDATA_W-1:0] hdr;
        hdr = '0;
        hdr[`LE_HDR_FLAG_LSB +: 16]      = flag;
        hdr[`LE_HDR_MOD_LSB +: 8]        = mod_id;
        hdr[`LE_HDR_SEL_LSB +: 4]        = sel;
        hdr[`LE_HDR_IDX_LSB +: `LE_IDX_W] = idx;
        return hdr;
    endfunction

    // lowest valid entry holding the key or -1 on a miss
    function automatic int find_entry(input key_t k);
        for (int i = 0; i < `LE_DEPTH; i++) begin
            if (model_vld[i] && (model_key[i] == k)) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic run_lookup(input key_t k, input phv_t p, input int hold);
        int      idx;
        int      lat;
        int      exp_lat;
        action_t exp_act;
        idx     = find_entry(k);
        exp_act = (idx < 0) ? action_t'(`LE_DEFAULT_ACT) : model_act[idx];
        exp_lat = (idx < 0) ? 2 : 3;
        action_ready = (hold == 0);
        key_valid    = 1'b1;
        key          = k;
        phv_in       = p;
        lat = 0;
        while (!key_ready && lat < WAIT_LIMIT) begin
            tick();
            lat++;
        end
        if (!key_ready) begin
            report_failure("key_ready never rose for a new lookup");
            key_valid = 1'b0;
            return;
        end
        tick();
        // scramble the inputs so the captured copy is what counts
        key_valid = 1'b0;
        key       = key_t'($urandom);
        phv_in    = phv_t'($urandom);
        lat = 0;
        while (!action_valid && lat < WAIT_LIMIT) begin
            tick();
            lat++;
        end
        if (!action_valid) begin
            report_failure("action_valid never rose after the key transfer");
            return;
        end
        if (lat != exp_lat) begin
            report_mismatch("action_valid latency", lat, exp_lat);
        end
        for (int i = 0; i < hold; i++) begin
            if (key_ready) begin
                report_failure("key_ready high while the result was stalled");
            end
            if (!action_valid) begin
                report_failure("action_valid dropped while action_ready was low");
            end
            if (action !== exp_act) begin
                report_mismatch("action", action, exp_act);
            end
            tick();
        end
        action_ready = 1'b1;
        if (action !== exp_act) begin
            report_mismatch("action", action, exp_act);
        end
        if (phv_out !== p) begin
            report_mismatch("phv_out", phv_out, p);
        end
        tick();
        if (action_valid) begin
            report_failure("action_valid stayed high after the action transfer");
        end
        if (!key_ready) begin
            report_failure("key_ready did not return after the action transfer");
        end
    endtask

    task automatic send_beat(input logic [`LE_CDATA_W-1:0] data, input logic last,
                             input logic fwd);
        int waited;
        c_s_valid = 1'b1;
        c_s_data  = data;
        c_s_last  = last;
        waited = 0;
        while (!c_s_ready && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (!c_s_ready) begin
            report_failure("c_s_ready stuck low on the control input");
            c_s_valid = 1'b0;
            return;
        end
        tick();
        c_s_valid = 1'b0;
        if (fwd) begin
            if (!c_m_valid) begin
                report_failure("foreign beat did not appear on c_m one cycle later");
            end else begin
                if (c_m_data !== data) begin
                    report_mismatch("c_m_data", c_m_data, data);
                end
                if (c_m_last !== last) begin
                    report_mismatch("c_m_last", c_m_last, last);
                end
            end
        end else if (c_m_valid) begin
            report_failure("addressed beat was forwarded on c_m");
        end
    endtask

    task automatic wait_ctrl_idle();
        int waited;
        waited = 0;
        while (!c_s_ready && waited < WAIT_LIMIT) begin
            tick();
            waited++;
        end
        if (!c_s_ready) begin
            report_failure("pending action write was never granted");
        end
    endtask

    task automatic test_miss_empty();
        int start_err;
        start_err = errors;
        for (int i = 0; i < 4; i++) begin
            run_lookup(key_t'($urandom), phv_t'($urandom), 0);
        end
        finish_test("miss on empty table", start_err);
    endtask

    task automatic test_program_hit();
        int start_err;
        int start_fwd;
        start_err = errors;
        start_fwd = fwd_seen;
        send_beat(make_header(`LE_CTRL_FLAG, OWN_ID, TBL_CAM, BASE_IDX), 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            prog_key[i] = key_t'($urandom);
            model_key[BASE_IDX + i] = prog_key[i];
            model_vld[BASE_IDX + i] = 1'b1;
            // upper half is ignored by a cam write
            send_beat({32'($urandom), prog_key[i]}, i == 2, 1'b0);
        end
        send_beat(make_header(`LE_CTRL_FLAG, OWN_ID, TBL_ACT, BASE_IDX), 1'b0, 1'b0);
        for (int i = 0; i < 3; i++) begin
            model_act[BASE_IDX + i] = {32'($urandom), 32'($urandom)};
            send_beat(model_act[BASE_IDX + i], i == 2, 1'b0);
        end
        wait_ctrl_idle();
        for (int i = 0; i < 3; i++) begin
            run_lookup(prog_key[i], phv_t'($urandom), 0);
        end
        run_lookup(key_t'($urandom), phv_t'($urandom), 0);
        if (fwd_seen != start_fwd) begin
            report_failure("programming packets showed up on c_m");
        end
        finish_test("programming and hit", start_err);
    endtask

    task automatic test_forwarding();
        int                     start_err;
        int                     start_fwd;
        logic [15:0]            flag;
        logic [7:0]             mod_id;
        logic [3:0]             sel;
        logic [`LE_CDATA_W-1:0] body;
        key_t                   stray_key;
        start_err = errors;
        start_fwd = fwd_seen;
        for (int p = 0; p < 3; p++) begin
            flag   = `LE_CTRL_FLAG;
            mod_id = OWN_ID;
            sel    = TBL_CAM;
            if (p == 0) begin
                flag = 16'h1f2e;
                sel  = TBL_ACT;
            end
            if (p == 1) begin
                mod_id = {5'd1, 3'(`LE_LOOKUP_ID)};
            end
            if (p == 2) begin
                mod_id = {5'(`LE_STAGE_ID), 3'd5};
            end
            send_beat(make_header(flag, mod_id, sel, BASE_IDX), 1'b0, 1'b1);
            for (int b = 0; b < 2; b++) begin
                body      = {32'($urandom), 32'($urandom)};
                stray_key = body[`LE_KEY_W-1:0];
                send_beat(body, b == 1, 1'b1);
            end
        end
        for (int i = 0; i < 3; i++) begin
            run_lookup(prog_key[i], phv_t'($urandom), 0);
        end
        run_lookup(stray_key, phv_t'($urandom), 0);
        if (fwd_seen - start_fwd != 9) begin
            report_mismatch("c_m_valid beat count", fwd_seen - start_fwd, 9);
        end
        finish_test("forwarding", start_err);
    endtask

    task automatic test_backpressure();
        int start_err;
        start_err = errors;
        run_lookup(prog_key[1], phv_t'($urandom), 6);
        run_lookup(key_t'($urandom), phv_t'($urandom), 4);
        run_lookup(prog_key[2], phv_t'($urandom), 0);
        finish_test("back-pressure", start_err);
    endtask

    task automatic test_overlap_overwrite();
        int      start_err;
        action_t new_a;
        action_t new_b;
        start_err = errors;
        new_a = {32'($urandom), 32'($urandom)};
        new_b = {32'($urandom), 32'($urandom)};
        // rewrite two actions while the untouched entry is looked up back to back
        fork
            begin
                send_beat(make_header(`LE_CTRL_FLAG, OWN_ID, TBL_ACT, BASE_IDX + 1),
                          1'b0, 1'b0);
                send_beat(new_a, 1'b0, 1'b0);
                send_beat(new_b, 1'b1, 1'b0);
                wait_ctrl_idle();
            end
            begin
                for (int i = 0; i < 4; i++) begin
                    run_lookup(prog_key[0], phv_t'($urandom), 0);
                end
            end
        join
        model_act[BASE_IDX + 1] = new_a;
        model_act[BASE_IDX + 2] = new_b;
        for (int i = 2; i >= 0; i--) begin
            run_lookup(prog_key[i], phv_t'($urandom), 0);
        end
        finish_test("overlap and overwrite", start_err);
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        key_valid    = 1'b0;
        key          = '0;
        phv_in       = '0;
        action_ready = 1'b1;
        c_s_valid    = 1'b0;
        c_s_data     = '0;
        c_s_last     = 1'b0;
        for (int i = 0; i < `LE_DEPTH; i++) begin
            model_vld[i] = 1'b0;
        end
        void'($urandom(60));
        repeat (8) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        tick();

        test_miss_empty();
        test_program_hit();
        test_forwarding();
        test_backpressure();
        test_overlap_overwrite();

        assert_fails = i_dut.i_lookup_engine_asserts.fail_cnt;
        $display("tests run %0d, tests failed %0d, errors %0d, assertion failures %0d",
                 tests_run, tests_failed, errors, assert_fails);
        if (errors == 0 && assert_fails == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// File: lookup_engine.f
+incdir+design
design/lookup_pkg.sv
design/ctrl_pkg.sv
design/key_cam.sv
design/action_table_arbiter.sv
design/lookup_ctrl.sv
design/ctrl_parser.sv
design/lookup_engine.sv
test/lookup_engine_asserts.sv
test/tb_lookup_engine.sv

// File: Bender.yml
package:
  name: lookup_engine

sources:
  - include_dirs:
      - design
    files:
      - design/lookup_pkg.sv
      - design/ctrl_pkg.sv
      - design/key_cam.sv
      - design/action_table_arbiter.sv
      - design/lookup_ctrl.sv
      - design/ctrl_parser.sv
      - design/lookup_engine.sv
  - target: test
    include_dirs:
      - design
    files:
      - test/lookup_engine_asserts.sv
      - test/tb_lookup_engine.sv
